// File: hw/rv32i_pkg.sv
package rv32i_pkg;

    localparam int unsigned xlen     = 32;
    localparam int unsigned num_regs = 32;  // Including hard-wired x0

    typedef logic [xlen-1:0] rv32i_word;
    typedef logic [4:0]      reg_addr_t;

    localparam rv32i_word pc_reset = '0;
    localparam rv32i_word pc_step  = 32'd4;

    // Load width encodings in funct3
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    typedef enum logic [6:0] {
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_ops;

    typedef enum logic [1:0] {
        wb_alu,
        wb_uimm,
        wb_load
    } wb_sel_t;

    typedef struct packed {
        logic       legal;
        alu_ops     alu_op;
        logic       src1_pc;      // Operand A is the PC
        logic       src2_imm;     // Operand B is the immediate
        wb_sel_t    wb_sel;
        logic       is_load;
        logic [2:0] load_funct3;
        reg_addr_t  rd;
    } ctrl_word_t;

endpackage

// File: hw/pipe_ifs.sv
`timescale 1ns/1ns

// Decode to execute, loaded on every clock
interface id_ex_if import rv32i_pkg::*; ();
    logic       valid;
    ctrl_word_t ctrl;
    rv32i_word  pc;
    rv32i_word  rs1_data;
    rv32i_word  rs2_data;
    rv32i_word  imm;

    modport src (output valid, ctrl, pc, rs1_data, rs2_data, imm);
    modport dst (input valid, ctrl, pc, rs1_data, rs2_data, imm);
endinterface

// Execute to writeback, i.e. the EX/MEM register
interface ex_wb_if import rv32i_pkg::*; ();
    logic       valid;
    reg_addr_t  rd;
    wb_sel_t    wb_sel;
    rv32i_word  result;       // ALU result or U immediate
    logic [2:0] load_funct3;
    logic [1:0] byte_off;     // Low address bits for lane select
    rv32i_word  pc;

    modport src (output valid, rd, wb_sel, result, load_funct3, byte_off, pc);
    modport dst (input valid, rd, wb_sel, result, load_funct3, byte_off, pc);
endinterface

// File: hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      inst_resp,
    input  rv32i_word inst_rdata,
    output rv32i_word inst_addr,
    output logic      inst_read,
    output logic      fetch_valid,
    output rv32i_word fetch_inst,
    output rv32i_word fetch_pc
);

    rv32i_word pc;
    logic      req_pending;  // Outstanding request level

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= pc_reset;
            req_pending <= 1'b0;
        end else if (req_pending && inst_resp) begin
            pc          <= pc + pc_step;
            req_pending <= 1'b0;  // Idle one cycle while the address moves on
        end else begin
            req_pending <= 1'b1;
        end
    end

    assign inst_addr = pc;
    assign inst_read = req_pending;

    // Returned word goes straight into IF/ID on this edge
    assign fetch_valid = req_pending & inst_resp;
    assign fetch_inst  = inst_rdata;
    assign fetch_pc    = pc;

endmodule

// File: hw/control_unit.sv
`timescale 1ns/1ns

module control_unit import rv32i_pkg::*; (
    input  rv32i_word  inst,
    output ctrl_word_t ctrl
);

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        funct7_alt;  // Bit 30 selects sub and sra
    alu_ops      arith_op;

    assign opcode     = rv32i_opcode'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7_alt = inst[30];

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == op_reg && funct7_alt) ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7_alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        ctrl             = '0;
        ctrl.alu_op      = alu_add;
        ctrl.wb_sel      = wb_alu;
        ctrl.load_funct3 = funct3;
        ctrl.rd          = inst[11:7];
        case (opcode)
            op_imm: begin
                ctrl.legal    = 1'b1;
                ctrl.alu_op   = arith_op;
                ctrl.src2_imm = 1'b1;
            end
            op_reg: begin
                ctrl.legal  = 1'b1;
                ctrl.alu_op = arith_op;
            end
            op_lui: begin
                ctrl.legal  = 1'b1;
                ctrl.wb_sel = wb_uimm;  // Immediate passes through execute
            end
            op_auipc: begin
                ctrl.legal    = 1'b1;
                ctrl.src1_pc  = 1'b1;
                ctrl.src2_imm = 1'b1;
            end
            op_load: begin
                ctrl.legal    = funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu};
                ctrl.src2_imm = 1'b1;
                ctrl.wb_sel   = wb_load;
                ctrl.is_load  = 1'b1;
            end
            default: ctrl.legal = 1'b0;  // Becomes a bubble
        endcase
    end

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ns

module reg_file import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output rv32i_word rs1_data,
    output rv32i_word rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  rv32i_word wr_data
);

    rv32i_word regs [1:num_regs-1];  // No storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-first bypass so a same-cycle write is seen by decode
    assign rs1_data = (rs1 == '0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      fetch_valid,
    input  rv32i_word fetch_inst,
    input  rv32i_word fetch_pc,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  rv32i_word wr_data,
    id_ex_if.src      id_ex
);

    logic       if_valid;
    rv32i_word  if_inst;
    rv32i_word  if_pc;
    ctrl_word_t ctrl;
    logic       upper_imm;
    rv32i_word  imm;
    rv32i_word  rs1_data;
    rv32i_word  rs2_data;

    // IF/ID
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            if_inst <= fetch_inst;
            if_pc   <= fetch_pc;
        end
    end

    control_unit control_unit_i (
        .inst (if_inst),
        .ctrl (ctrl)
    );

    // U format for lui and auipc, I format for everything else
    assign upper_imm = (if_inst[6:0] == op_lui) || (if_inst[6:0] == op_auipc);
    assign imm = upper_imm ? {if_inst[31:12], 12'b0} : {{20{if_inst[31]}}, if_inst[31:20]};

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (if_inst[19:15]),
        .rs2      (if_inst[24:20]),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // ID/EX
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex.valid <= if_valid & ctrl.legal;  // Illegal opcodes drop out here
        end
    end

    always_ff @(posedge clk) begin
        id_ex.ctrl     <= ctrl;
        id_ex.pc       <= if_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    id_ex_if.dst       id_ex,
    ex_wb_if.src       ex_wb,
    output rv32i_word  data_addr,
    output logic [3:0] data_mbe,
    output logic       data_read
);

    rv32i_word op_a;
    rv32i_word op_b;
    logic [4:0] shamt;
    rv32i_word alu_result;

    assign op_a  = id_ex.ctrl.src1_pc ? id_ex.pc : id_ex.rs1_data;
    assign op_b  = id_ex.ctrl.src2_imm ? id_ex.imm : id_ex.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $signed(op_a) >>> shamt;
            alu_or:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase
    end

    // Load request leaves in the EX cycle, data lands in the MEM cycle
    assign data_read = id_ex.valid & id_ex.ctrl.is_load;
    assign data_addr = {alu_result[31:2], 2'b00};

    always_comb begin
        case (id_ex.ctrl.load_funct3)
            f3_lb, f3_lbu: data_mbe = 4'b0001 << alu_result[1:0];
            f3_lh, f3_lhu: data_mbe = 4'b0011 << alu_result[1:0];
            default:       data_mbe = 4'b1111;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb.rd          <= id_ex.ctrl.rd;
        ex_wb.wb_sel      <= id_ex.ctrl.wb_sel;
        ex_wb.load_funct3 <= id_ex.ctrl.load_funct3;
        ex_wb.byte_off    <= alu_result[1:0];
        ex_wb.pc          <= id_ex.pc;
        // lui carries its immediate in the result field
        ex_wb.result <= (id_ex.ctrl.wb_sel == wb_uimm) ? id_ex.imm : alu_result;
    end

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    ex_wb_if.dst      ex_wb,
    input  rv32i_word data_rdata,
    input  logic      data_resp,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output rv32i_word wr_data,
    output logic      commit_valid,
    output rv32i_word commit_pc,
    output reg_addr_t commit_rd,
    output rv32i_word commit_data
);

    logic       mw_valid;
    reg_addr_t  mw_rd;
    wb_sel_t    mw_sel;
    rv32i_word  mw_result;
    logic [2:0] mw_funct3;
    logic [1:0] mw_off;
    rv32i_word  mw_pc;
    rv32i_word  mw_rdata;
    rv32i_word  lane;
    rv32i_word  load_value;
    rv32i_word  wb_value;

    // MEM/WB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mw_valid <= 1'b0;
        end else begin
            mw_valid <= ex_wb.valid;
        end
    end

    always_ff @(posedge clk) begin
        mw_rd     <= ex_wb.rd;
        mw_sel    <= ex_wb.wb_sel;
        mw_result <= ex_wb.result;
        mw_funct3 <= ex_wb.load_funct3;
        mw_off    <= ex_wb.byte_off;
        mw_pc     <= ex_wb.pc;
        if (data_resp) begin
            mw_rdata <= data_rdata;
        end
    end

    assign lane = mw_rdata >> {mw_off, 3'b000};  // Addressed byte moved to bit 0

    always_comb begin
        case (mw_funct3)
            f3_lb:   load_value = {{24{lane[7]}}, lane[7:0]};
            f3_lh:   load_value = {{16{lane[15]}}, lane[15:0]};
            f3_lbu:  load_value = {24'b0, lane[7:0]};
            f3_lhu:  load_value = {16'b0, lane[15:0]};
            default: load_value = mw_rdata;  // lw
        endcase
    end

    always_comb begin
        case (mw_sel)
            wb_load: wb_value = load_value;
            default: wb_value = mw_result;  // ALU result or U immediate
        endcase
    end

    assign wr_en   = mw_valid;
    assign wr_addr = mw_rd;
    assign wr_data = wb_value;

    // Monitor view, x0 reports zero
    assign commit_valid = mw_valid;
    assign commit_pc    = mw_pc;
    assign commit_rd    = mw_rd;
    assign commit_data  = (mw_rd == '0) ? '0 : wb_value;

endmodule

// File: hw/rv32i_core.sv
`timescale 1ns/1ns

module rv32i_core import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    input  rv32i_word  inst_rdata,
    input  logic       inst_resp,
    output rv32i_word  inst_addr,
    output logic       inst_read,

    input  rv32i_word  data_rdata,
    input  logic       data_resp,
    output rv32i_word  data_addr,
    output logic [3:0] data_mbe,
    output logic       data_read,

    output logic       commit_valid,
    output rv32i_word  commit_pc,
    output reg_addr_t  commit_rd,
    output rv32i_word  commit_data
);

    logic      fetch_valid;
    rv32i_word fetch_inst;
    rv32i_word fetch_pc;
    logic      wr_en;
    reg_addr_t wr_addr;
    rv32i_word wr_data;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .inst_resp   (inst_resp),
        .inst_rdata  (inst_rdata),
        .inst_addr   (inst_addr),
        .inst_read   (inst_read),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc)
    );

    decode_stage decode_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .id_ex       (id_ex.src)
    );

    execute_stage execute_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_ex     (id_ex.dst),
        .ex_wb     (ex_wb.src),
        .data_addr (data_addr),
        .data_mbe  (data_mbe),
        .data_read (data_read)
    );

    // Register write loops back into decode
    writeback_stage writeback_stage_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_wb        (ex_wb.dst),
        .data_rdata   (data_rdata),
        .data_resp    (data_resp),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

// File: verif/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;  // 20 ns period
        end
    end

endmodule

// File: verif/core_properties.sv
`timescale 1ns/1ns

module core_properties import rv32i_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input logic      inst_read,
    input logic      inst_resp,
    input rv32i_word inst_addr,
    input logic      data_read,
    input logic      data_resp,
    input logic      commit_valid
);

    int unsigned failures = 0;  // Count of failed assertions

    // Memory must answer a load in the very next cycle
    assert property (@(posedge clk) disable iff (!arst_n) data_read |=> data_resp)
    else begin
        $error("data_resp missing in the cycle after data_read");
        failures++;
    end

    // Pending instruction request holds its address
    assert property (@(posedge clk) disable iff (!arst_n)
        inst_read && !inst_resp |=> inst_read && $stable(inst_addr))
    else begin
        $error("inst_addr or inst_read changed before inst_resp");
        failures++;
    end

    assert property (@(posedge clk) $rose(arst_n) |-> !commit_valid [*4])
    else begin
        $error("commit_valid seen within four cycles of reset release");
        failures++;
    end

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ns

module core_tb import rv32i_pkg::*; ();

    logic       clk;
    logic       arst_n;
    rv32i_word  inst_rdata;
    logic       inst_resp;
    rv32i_word  inst_addr;
    logic       inst_read;
    rv32i_word  data_rdata;
    logic       data_resp;
    rv32i_word  data_addr;
    logic [3:0] data_mbe;
    logic       data_read;
    logic       commit_valid;
    rv32i_word  commit_pc;
    reg_addr_t  commit_rd;
    rv32i_word  commit_data;

    // Program table with one entry per instruction
    rv32i_word prog_inst[$];
    int        exp_rd[$];
    rv32i_word exp_data[$];
    bit        exp_commit[$];

    // Data port requests in program order
    rv32i_word  exp_addr[$];
    logic [3:0] exp_mbe[$];

    rv32i_word imem [256];
    rv32i_word dmem [16];

    int row;
    int commits_seen;
    int expected_commits;
    int cycles;
    int cycle_limit;
    int checks;
    int value_errors;
    int other_errors;

    clock_gen clock_gen_i (.clk(clk));

    rv32i_core dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_rdata   (inst_rdata),
        .inst_resp    (inst_resp),
        .inst_addr    (inst_addr),
        .inst_read    (inst_read),
        .data_rdata   (data_rdata),
        .data_resp    (data_resp),
        .data_addr    (data_addr),
        .data_mbe     (data_mbe),
        .data_read    (data_read),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    bind rv32i_core core_properties props_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_read    (inst_read),
        .inst_resp    (inst_resp),
        .inst_addr    (inst_addr),
        .data_read    (data_read),
        .data_resp    (data_resp),
        .commit_valid (commit_valid)
    );

    function automatic rv32i_word i_type(rv32i_opcode op, int rd, logic [2:0] f3, int rs1,
                                         int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic rv32i_word r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                         int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic rv32i_word u_type(rv32i_opcode op, int rd, logic [19:0] imm20);
        return {imm20, rd[4:0], op};
    endfunction

    task automatic add_row(input rv32i_word inst, input int rd, input rv32i_word data);
        prog_inst.push_back(inst);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_commit.push_back(1'b1);
        expected_commits++;
    endtask

    task automatic add_load(input rv32i_word inst, input int rd, input rv32i_word data,
                            input rv32i_word addr, input logic [3:0] mbe);
        exp_addr.push_back(addr);
        exp_mbe.push_back(mbe);
        add_row(inst, rd, data);
    endtask

    task automatic add_bubble(input rv32i_word inst);
        prog_inst.push_back(inst);
        exp_rd.push_back(0);
        exp_data.push_back('0);
        exp_commit.push_back(1'b0);
    endtask

    // Consumers sit at least three rows after their producers
    task automatic build_program();
        add_row(i_type(op_imm, 1, 3'd0, 0, 100), 1, 32'h0000_0064);
        add_row(i_type(op_imm, 2, 3'd0, 0, -1), 2, 32'hFFFF_FFFF);
        add_row(i_type(op_imm, 3, 3'd0, 0, -2048), 3, 32'hFFFF_F800);
        add_row(u_type(op_lui, 4, 20'h80000), 4, 32'h8000_0000);
        add_row(i_type(op_imm, 5, 3'd0, 1, -300), 5, 32'hFFFF_FF38);
        add_row(i_type(op_imm, 6, 3'd2, 2, 0), 6, 32'h0000_0001);     // slti
        add_row(i_type(op_imm, 7, 3'd3, 2, 1), 7, 32'h0000_0000);     // sltiu
        add_row(i_type(op_imm, 8, 3'd4, 3, -1), 8, 32'h0000_07FF);
        add_row(i_type(op_imm, 9, 3'd6, 1, 32'hF0), 9, 32'h0000_00F4);
        add_row(i_type(op_imm, 10, 3'd7, 2, 32'h7F0), 10, 32'h0000_07F0);
        add_row(i_type(op_imm, 11, 3'd1, 1, 4), 11, 32'h0000_0640);
        add_row(i_type(op_imm, 12, 3'd5, 4, 31), 12, 32'h0000_0001);
        add_row(i_type(op_imm, 13, 3'd5, 4, 32'h404), 13, 32'hF800_0000);  // srai
        add_row(i_type(op_imm, 0, 3'd0, 1, 5), 0, 32'h0000_0000);     // Write to x0
        add_row(r_type(7'h00, 1, 0, 3'd0, 14), 14, 32'h0000_0064);
        add_row(i_type(op_imm, 15, 3'd0, 0, 7), 15, 32'h0000_0007);
        add_row(i_type(op_imm, 16, 3'd0, 0, -8), 16, 32'hFFFF_FFF8);
        add_row(i_type(op_imm, 17, 3'd0, 0, 33), 17, 32'h0000_0021);
        add_row(r_type(7'h20, 2, 15, 3'd0, 18), 18, 32'h0000_0008);   // sub
        add_row(r_type(7'h20, 15, 16, 3'd5, 19), 19, 32'hFFFF_FFFF);  // sra
        add_row(r_type(7'h00, 17, 17, 3'd1, 20), 20, 32'h0000_0042);
        add_row(r_type(7'h00, 18, 4, 3'd2, 21), 21, 32'h0000_0001);   // slt
        add_row(r_type(7'h00, 19, 4, 3'd3, 22), 22, 32'h0000_0001);   // sltu
        add_row(r_type(7'h00, 20, 16, 3'd3, 23), 23, 32'h0000_0000);
        add_row(r_type(7'h00, 21, 2, 3'd4, 24), 24, 32'hFFFF_FFFE);
        add_row(r_type(7'h00, 22, 4, 3'd5, 25), 25, 32'h4000_0000);   // srl
        add_row(r_type(7'h00, 1, 23, 3'd6, 26), 26, 32'h0000_0064);
        add_row(r_type(7'h00, 3, 24, 3'd7, 27), 27, 32'hFFFF_F800);
        add_row(r_type(7'h00, 4, 25, 3'd0, 28), 28, 32'hC000_0000);
        add_row(u_type(op_lui, 29, 20'hABCDE), 29, 32'hABCD_E000);
        add_row(u_type(op_auipc, 30, 20'h12345), 30, 32'h1234_5078);
        add_row(u_type(op_auipc, 31, 20'hFFFFF), 31, 32'hFFFF_F07C);
        add_bubble(32'h0010_2023);                                    // Store is unsupported
        add_bubble(i_type(op_load, 5, 3'b011, 0, 16));                // Bad load width
        add_load(i_type(op_load, 1, f3_lb, 0, 16), 1, 32'hFFFF_FF81, 32'h10, 4'b0001);
        add_load(i_type(op_load, 2, f3_lb, 0, 17), 2, 32'h0000_007F, 32'h10, 4'b0010);
        add_load(i_type(op_load, 3, f3_lb, 0, 18), 3, 32'hFFFF_FFF0, 32'h10, 4'b0100);
        add_load(i_type(op_load, 5, f3_lb, 0, 19), 5, 32'h0000_0012, 32'h10, 4'b1000);
        add_load(i_type(op_load, 6, f3_lbu, 0, 16), 6, 32'h0000_0081, 32'h10, 4'b0001);
        add_load(i_type(op_load, 7, f3_lbu, 0, 17), 7, 32'h0000_007F, 32'h10, 4'b0010);
        add_load(i_type(op_load, 8, f3_lbu, 0, 18), 8, 32'h0000_00F0, 32'h10, 4'b0100);
        add_load(i_type(op_load, 9, f3_lbu, 0, 19), 9, 32'h0000_0012, 32'h10, 4'b1000);
        add_load(i_type(op_load, 10, f3_lh, 0, 16), 10, 32'h0000_7F81, 32'h10, 4'b0011);
        add_load(i_type(op_load, 11, f3_lh, 0, 18), 11, 32'h0000_12F0, 32'h10, 4'b1100);
        add_load(i_type(op_load, 12, f3_lh, 0, 20), 12, 32'hFFFF_FFFE, 32'h14, 4'b0011);
        add_load(i_type(op_load, 13, f3_lh, 0, 22), 13, 32'hFFFF_8001, 32'h14, 4'b1100);
        add_load(i_type(op_load, 14, f3_lhu, 0, 20), 14, 32'h0000_FFFE, 32'h14, 4'b0011);
        add_load(i_type(op_load, 15, f3_lhu, 0, 22), 15, 32'h0000_8001, 32'h14, 4'b1100);
        add_load(i_type(op_load, 16, f3_lw, 0, 20), 16, 32'h8001_FFFE, 32'h14, 4'b1111);
        add_load(i_type(op_load, 17, f3_lw, 0, 16), 17, 32'h12F0_7F81, 32'h10, 4'b1111);
        add_load(i_type(op_load, 18, f3_lw, 0, 8), 18, 32'h5A5A_0008, 32'h08, 4'b1111);
        add_row(r_type(7'h00, 1, 16, 3'd0, 19), 19, 32'h8001_FF7F);
    endtask

    task automatic check_value(input string field, input rv32i_word got,
                               input rv32i_word expected);
        checks++;
        if (got !== expected) begin
            value_errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, field, got, expected);
        end
    endtask

    // Instruction memory adds 0 to 2 extra cycles per response
    initial begin
        int wait_left;
        void'($urandom(63));
        inst_resp  = 1'b0;
        inst_rdata = '0;
        wait_left  = -1;
        forever begin
            @(negedge clk);
            if (!arst_n || !inst_read || inst_resp) begin
                inst_resp = 1'b0;
                wait_left = -1;
            end else begin
                if (wait_left < 0) begin
                    wait_left = $urandom_range(2, 0);
                end
                if (wait_left == 0) begin
                    inst_resp  = 1'b1;
                    inst_rdata = imem[inst_addr[9:2]];
                    wait_left  = -1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // Data memory answers in the cycle after data_read
    initial begin
        logic       load_pending;
        logic [3:0] load_index;
        rv32i_word  want_addr;
        logic [3:0] want_mbe;
        data_resp    = 1'b0;
        data_rdata   = '0;
        load_pending = 1'b0;
        load_index   = '0;
        for (int i = 0; i < 16; i++) begin
            dmem[i] = 32'h5A5A_0000 + rv32i_word'(i * 4);
        end
        dmem[4] = 32'h12F0_7F81;  // Mixed sign bytes
        dmem[5] = 32'h8001_FFFE;  // Negative half-words
        forever begin
            @(negedge clk);
            if (!arst_n) begin
                data_resp    = 1'b0;
                load_pending = 1'b0;
            end else begin
                data_resp = load_pending;
                if (load_pending) begin
                    data_rdata = dmem[load_index];
                end
                if (data_read === 1'b1) begin
                    if (exp_mbe.size() == 0) begin
                        other_errors++;
                        $display("Load request at %h with no load left in the program",
                                 data_addr);
                    end else begin
                        want_addr = exp_addr.pop_front();
                        want_mbe  = exp_mbe.pop_front();
                        check_value("data_addr", data_addr, want_addr);
                        check_value("data_mbe", rv32i_word'(data_mbe), rv32i_word'(want_mbe));
                    end
                end
                load_pending = data_read;
                load_index   = data_addr[5:2];
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
        end
    end

    // Commit checker skips rows that must not retire
    always @(negedge clk) begin
        if (arst_n && commit_valid === 1'b1) begin
            while (row < prog_inst.size() && !exp_commit[row]) begin
                row++;
            end
            if (row >= prog_inst.size()) begin
                other_errors++;
                $display("Unexpected commit from pc %h after the end of the program", commit_pc);
            end else begin
                check_value("commit_pc", commit_pc, rv32i_word'(row * 4));
                check_value("commit_rd", rv32i_word'(commit_rd), rv32i_word'(exp_rd[row]));
                check_value("commit_data", commit_data, exp_data[row]);
                row++;
                commits_seen++;
            end
        end
    end

    initial begin
        arst_n           = 1'b0;
        row              = 0;
        commits_seen     = 0;
        expected_commits = 0;
        cycles           = 0;
        checks           = 0;
        value_errors     = 0;
        other_errors     = 0;
        build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h7F};  // Unsupported opcode past the program
        end
        for (int i = 0; i < prog_inst.size(); i++) begin
            imem[i] = prog_inst[i];
        end
        cycle_limit = prog_inst.size() * 4 + 40;

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        while (commits_seen < expected_commits && cycles < cycle_limit) begin
            @(negedge clk);
        end
        if (commits_seen < expected_commits) begin
            other_errors++;
            $display("Timeout after %0d cycles: only %0d of %0d instructions committed",
                     cycles, commits_seen, expected_commits);
        end
        repeat (10) @(negedge clk);  // Room for any stray commit
        if (exp_mbe.size() != 0) begin
            other_errors++;
            $display("%0d load requests never reached the data port", exp_mbe.size());
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertion failures: %0d",
                 checks, value_errors, other_errors, dut_i.props_i.failures);
        if (value_errors == 0 && other_errors == 0 && dut_i.props_i.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/rv32i_pkg.sv
hw/pipe_ifs.sv
hw/fetch_unit.sv
hw/control_unit.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/rv32i_core.sv
verif/clock_gen.sv
verif/core_properties.sv
verif/core_tb.sv
